//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := usb_fs_rx_tb
FILELIST  := usb_fs_rx.f
OBJ_DIR   := obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/usb_bit_sampler.sv
// Phase locks only on line transitions and relies on bit stuffing to bound drift; strobe comes 3 cycles after an edge
`timescale 1ns/10ps
`default_nettype none

`include "usb_fs_rx_consts.svh"

module usb_bit_sampler (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire usb_rx_pkg::line_state_e line_state,
    output logic                    bit_strobe,
    output usb_rx_pkg::line_state_e bit_sym
);

    localparam int PHASE_W = $clog2(`USB_OVERSAMPLE);
    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`USB_OVERSAMPLE - 1);
    // Registered strobe set one phase early so it lands mid-bit
    localparam logic [PHASE_W-1:0] PHASE_PRE = PHASE_W'(`USB_OVERSAMPLE / 2 - 1);

    usb_rx_pkg::line_state_e last_state;
    logic [PHASE_W-1:0]      phase;
    logic                    edge_seen;
    logic                    take_sample;

    assign edge_seen   = (line_state != last_state);
    assign take_sample = (phase == PHASE_PRE) && !edge_seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_state <= usb_rx_pkg::J;
        end else begin
            last_state <= line_state;
        end
    end

    // Restart the bit period on every transition
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (edge_seen || phase == PHASE_LAST) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_strobe <= 1'b0;
        end else begin
            bit_strobe <= take_sample;
        end
    end

    always_ff @(posedge clk) begin
        if (take_sample) begin
            bit_sym <= line_state;
        end
    end

endmodule

`default_nettype wire

//--- hdl/usb_fs_rx.sv
// Full-speed receive path only; no transmit, no low speed, no suspend or resume handling
`timescale 1ns/10ps
`default_nettype none

module usb_fs_rx (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     dp,
    input  wire                     dm,
    output usb_rx_pkg::line_state_e line_state,
    output logic                    j_state,
    output logic                    k_state,
    output logic                    se0_state,
    output logic                    se1_state,
    output logic                    reset_detected,
    output logic                    rx_active,
    output logic                    rx_valid,
    output logic                    rx_error,
    output logic [7:0]              rx_data
);

    logic                    bit_strobe;
    usb_rx_pkg::line_state_e bit_sym;

    logic bit_valid;
    logic bit_data;
    logic eop;
    logic stuff_error;

    usb_line_state_detector u_detector (
        .clk            (clk),
        .rst_n          (rst_n),
        .dp             (dp),
        .dm             (dm),
        .line_state     (line_state),
        .j_state        (j_state),
        .k_state        (k_state),
        .se0_state      (se0_state),
        .se1_state      (se1_state),
        .reset_detected (reset_detected)
    );

    usb_bit_sampler u_sampler (
        .clk        (clk),
        .rst_n      (rst_n),
        .line_state (line_state),
        .bit_strobe (bit_strobe),
        .bit_sym    (bit_sym)
    );

    usb_nrzi_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .bit_strobe  (bit_strobe),
        .bit_sym     (bit_sym),
        .bit_valid   (bit_valid),
        .bit_data    (bit_data),
        .eop         (eop),
        .stuff_error (stuff_error)
    );

    usb_rx_packet u_packet (
        .clk         (clk),
        .rst_n       (rst_n),
        .bit_valid   (bit_valid),
        .bit_data    (bit_data),
        .eop         (eop),
        .stuff_error (stuff_error),
        .rx_active   (rx_active),
        .rx_valid    (rx_valid),
        .rx_error    (rx_error),
        .rx_data     (rx_data)
    );

endmodule

`default_nettype wire

//--- hdl/usb_line_state_detector.sv
// Expects clean single-ended dp/dm with no glitch filter; line_state lags 3 cycles and the flags lag 4
`timescale 1ns/10ps
`default_nettype none

`include "usb_fs_rx_consts.svh"

module usb_line_state_detector (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     dp,
    input  wire                     dm,
    output usb_rx_pkg::line_state_e line_state,
    output logic                    j_state,
    output logic                    k_state,
    output logic                    se0_state,
    output logic                    se1_state,
    output logic                    reset_detected
);

    logic                    dp_q;
    logic                    dm_q;
    usb_rx_pkg::line_state_e curr_state;

    // Decode stage ahead of the output registers
    logic j_dec;
    logic k_dec;
    logic se0_dec;
    logic se1_dec;

    logic [7:0] se0_count;
    logic       reset_dec;

    // First stage captures the asynchronous pins
    // Capture resets to J so no false SE0 shows after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_q <= 1'b1;
            dm_q <= 1'b0;
        end else begin
            dp_q <= dp;
            dm_q <= dm;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_state <= usb_rx_pkg::J;
        end else begin
            curr_state <= usb_rx_pkg::line_state_e'({dp_q, dm_q});
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            j_dec   <= 1'b0;
            k_dec   <= 1'b0;
            se0_dec <= 1'b0;
            se1_dec <= 1'b0;
        end else begin
            j_dec   <= (curr_state == usb_rx_pkg::J);
            k_dec   <= (curr_state == usb_rx_pkg::K);
            se0_dec <= (curr_state == usb_rx_pkg::SE0);
            se1_dec <= (curr_state == usb_rx_pkg::SE1);
        end
    end

    // SE0 duration, saturating at 255
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            se0_count <= 8'd0;
        end else if (curr_state == usb_rx_pkg::SE0) begin
            if (se0_count != 8'd255) begin
                se0_count <= se0_count + 8'd1;
            end
        end else begin
            se0_count <= 8'd0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reset_dec <= 1'b0;
        end else begin
            reset_dec <= (se0_count > 8'(`USB_RESET_SE0_CYCLES));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_state     <= usb_rx_pkg::J;
            j_state        <= 1'b0;
            k_state        <= 1'b0;
            se0_state      <= 1'b0;
            se1_state      <= 1'b0;
            reset_detected <= 1'b0;
        end else begin
            line_state     <= curr_state;
            j_state        <= j_dec;
            k_state        <= k_dec;
            se0_state      <= se0_dec;
            se1_state      <= se1_dec;
            reset_detected <= reset_dec;
        end
    end

endmodule

`default_nettype wire

//--- hdl/usb_nrzi_decoder.sv
// Outputs lag the strobe by one cycle; after a stuffing error the bit stream resumes at the next zero
`timescale 1ns/10ps
`default_nettype none

`include "usb_fs_rx_consts.svh"

module usb_nrzi_decoder (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     bit_strobe,
    input  wire usb_rx_pkg::line_state_e bit_sym,
    output logic                    bit_valid,
    output logic                    bit_data,
    output logic                    eop,
    output logic                    stuff_error
);

    localparam int CNT_W = $clog2(`USB_STUFF_RUN + 2);
    localparam logic [CNT_W-1:0] RUN_FULL = CNT_W'(`USB_STUFF_RUN);
    // Run overflowed and the next zero is real data again
    localparam logic [CNT_W-1:0] RUN_OVER = CNT_W'(`USB_STUFF_RUN + 1);

    usb_rx_pkg::line_state_e prev_sym;
    logic [CNT_W-1:0]        ones_cnt;
    logic                    nrzi_bit;

    // No transition means a one
    assign nrzi_bit = (bit_sym == prev_sym);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_sym    <= usb_rx_pkg::J;
            ones_cnt    <= '0;
            bit_valid   <= 1'b0;
            eop         <= 1'b0;
            stuff_error <= 1'b0;
        end else begin
            bit_valid   <= 1'b0;
            eop         <= 1'b0;
            stuff_error <= 1'b0;
            if (bit_strobe) begin
                case (bit_sym)
                    usb_rx_pkg::SE0: begin
                        eop      <= 1'b1;
                        prev_sym <= usb_rx_pkg::J;
                        ones_cnt <= '0;
                    end
                    usb_rx_pkg::SE1: begin
                        stuff_error <= 1'b1;
                    end
                    default: begin
                        prev_sym <= bit_sym;
                        if (ones_cnt == RUN_FULL) begin
                            // Stuffed slot; a zero here is dropped
                            if (nrzi_bit) begin
                                stuff_error <= 1'b1;
                                ones_cnt    <= RUN_OVER;
                            end else begin
                                ones_cnt <= '0;
                            end
                        end else if (ones_cnt == RUN_OVER) begin
                            if (!nrzi_bit) begin
                                bit_valid <= 1'b1;
                                ones_cnt  <= '0;
                            end
                        end else begin
                            bit_valid <= 1'b1;
                            ones_cnt  <= nrzi_bit ? ones_cnt + 1'b1 : '0;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bit_strobe) begin
            bit_data <= nrzi_bit;
        end
    end

endmodule

`default_nettype wire

//--- hdl/usb_rx_packet.sv
// No PID or CRC check; stuffing errors before SYNC are taken as idle line and not reported
`timescale 1ns/10ps
`default_nettype none

`include "usb_fs_rx_consts.svh"

module usb_rx_packet (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        bit_valid,
    input  wire        bit_data,
    input  wire        eop,
    input  wire        stuff_error,
    output logic       rx_active,
    output logic       rx_valid,
    output logic       rx_error,
    output logic [7:0] rx_data
);

    usb_rx_pkg::rx_state_e state;

    // Shared shift window for SYNC hunt and byte assembly
    logic [7:0] window;
    logic [7:0] win_next;
    logic [2:0] bit_cnt;
    logic       byte_done;

    // LSB first so new bits enter at the top
    assign win_next  = {bit_data, window[7:1]};
    assign byte_done = (state == usb_rx_pkg::DATA) && bit_valid && !stuff_error && !eop &&
                       (bit_cnt == 3'd7);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= usb_rx_pkg::IDLE;
            window    <= 8'hFF;
            bit_cnt   <= 3'd0;
            rx_active <= 1'b0;
            rx_valid  <= 1'b0;
            rx_error  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            rx_error <= 1'b0;
            case (state)
                usb_rx_pkg::IDLE, usb_rx_pkg::SYNC: begin
                    if (eop || stuff_error) begin
                        state <= usb_rx_pkg::IDLE;
                    end else if (bit_valid) begin
                        window <= win_next;
                        if (win_next == `USB_SYNC_BYTE) begin
                            state     <= usb_rx_pkg::DATA;
                            rx_active <= 1'b1;
                            bit_cnt   <= 3'd0;
                        end else if (!bit_data) begin
                            // Idle line gives only ones, a zero starts SYNC
                            state <= usb_rx_pkg::SYNC;
                        end
                    end
                end
                usb_rx_pkg::DATA: begin
                    if (stuff_error) begin
                        state     <= usb_rx_pkg::DRAIN;
                        rx_active <= 1'b0;
                        rx_error  <= 1'b1;
                    end else if (eop) begin
                        // Partial byte at EOP
                        rx_error  <= (bit_cnt != 3'd0);
                        state     <= usb_rx_pkg::IDLE;
                        rx_active <= 1'b0;
                        window    <= 8'hFF;
                    end else if (bit_valid) begin
                        window   <= win_next;
                        bit_cnt  <= bit_cnt + 3'd1;
                        rx_valid <= byte_done;
                    end
                end
                usb_rx_pkg::DRAIN: begin
                    if (eop) begin
                        state  <= usb_rx_pkg::IDLE;
                        window <= 8'hFF;
                    end
                end
                default: begin
                    state <= usb_rx_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (byte_done) begin
            rx_data <= win_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/usb_rx_pkg.sv
// Types shared by the full-speed receive path; the line-state codes follow {dp, dm} and must not be reordered
`default_nettype none

package usb_rx_pkg;

    // Bus state as {dp, dm}
    typedef enum logic [1:0] {
        SE0 = 2'b00,
        K   = 2'b01,
        J   = 2'b10,
        SE1 = 2'b11
    } line_state_e;

    // Packet receiver states
    // DRAIN holds off byte delivery after a stuffing error until EOP
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        SYNC  = 2'b01,
        DATA  = 2'b10,
        DRAIN = 2'b11
    } rx_state_e;

endpackage

`default_nettype wire

//--- include/usb_fs_rx_consts.svh
// Full-speed receive only; the timing constants assume a 48 MHz clock, so retune them for any other rate
`ifndef USB_FS_RX_CONSTS_SVH
`define USB_FS_RX_CONSTS_SVH

// Clock cycles per USB bit (48 MHz / 12 Mbit/s)
`define USB_OVERSAMPLE 4

// SE0 cycles that must be exceeded before a bus reset is flagged
// 120 cycles is about 2.5 us at 48 MHz
`define USB_RESET_SE0_CYCLES 120

// Consecutive ones before the transmitter inserts a zero
`define USB_STUFF_RUN 6

// Decoded SYNC field as seen LSB first
`define USB_SYNC_BYTE 8'h80

`endif

//--- tests/usb_fs_rx_assert.sv
// The one-hot check waits four cycles after reset release until the line flags fill the pipeline
`timescale 1ns/10ps
`default_nettype none

module usb_fs_rx_assert (
    input wire clk,
    input wire rst_n,
    input wire j_state,
    input wire k_state,
    input wire se0_state,
    input wire se1_state,
    input wire reset_detected,
    input wire rx_active,
    input wire rx_valid
);

    logic [2:0] settle_cnt;

    // Cycles since reset release saturate at 7
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            settle_cnt <= 3'd0;
        end else if (settle_cnt != 3'd7) begin
            settle_cnt <= settle_cnt + 3'd1;
        end
    end

    flags_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
        (settle_cnt >= 3'd4) |-> $onehot({j_state, k_state, se0_state, se1_state}))
        else $error("Line flags are not one-hot");

    valid_inside_active: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |-> rx_active)
        else $error("rx_valid high while rx_active is low");

    reset_quiet_after_release: assert property (@(posedge clk) disable iff (!rst_n)
        (settle_cnt < 3'd6) |-> !reset_detected)
        else $error("reset_detected high within six cycles of reset release");

endmodule

bind usb_fs_rx usb_fs_rx_assert u_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .j_state        (j_state),
    .k_state        (k_state),
    .se0_state      (se0_state),
    .se1_state      (se1_state),
    .reset_detected (reset_detected),
    .rx_active      (rx_active),
    .rx_valid       (rx_valid)
);

`default_nettype wire

//--- tests/usb_fs_rx_tb.sv
// Drives ideal dp/dm levels at exactly USB_OVERSAMPLE cycles per bit; no jitter, drift or low speed
`timescale 1ns/10ps
`default_nettype none

`include "usb_fs_rx_consts.svh"

module usb_fs_rx_tb;

    logic clk;
    logic rst_n;
    logic dp;
    logic dm;

    usb_rx_pkg::line_state_e line_state;
    logic       j_state;
    logic       k_state;
    logic       se0_state;
    logic       se1_state;
    logic       reset_detected;
    logic       rx_active;
    logic       rx_valid;
    logic       rx_error;
    logic [7:0] rx_data;

    logic [31:0] lfsr;
    logic [7:0]  tx_bytes[$];
    logic [7:0]  got_bytes[$];
    logic        active_seen;
    logic        error_seen;

    usb_fs_rx DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Receive monitor, sampled on the falling edge where outputs are stable
    always @(negedge clk) begin
        if (rx_valid) begin
            got_bytes.push_back(rx_data);
        end
        if (rx_error) begin
            error_seen = 1'b1;
        end
        if (rx_active) begin
            active_seen = 1'b1;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_line(input string name, input usb_rx_pkg::line_state_e exp,
                              input usb_rx_pkg::line_state_e act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch at %0t: %s expected %s, actual %s",
                                $time, name, exp.name(), act.name()));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch at %0t: %s expected %h, actual %h",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch at %0t: %s expected %b, actual %b",
                                $time, name, exp, act));
        end
    endtask

    // Galois LFSR, right shifting form of x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'hA300_0000;
        end
        return n;
    endfunction

    task automatic take_random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic usb_rx_pkg::line_state_e flip_symbol(input usb_rx_pkg::line_state_e s);
        return (s == usb_rx_pkg::J) ? usb_rx_pkg::K : usb_rx_pkg::J;
    endfunction

    task automatic hold_symbol(input usb_rx_pkg::line_state_e s);
        {dp, dm} = s;
        repeat (`USB_OVERSAMPLE) next_cycle();
    endtask

    // NRZI encoder with bit stuffing; skip_stuff leaves out the first stuffed zero
    task automatic send_packet(input logic skip_stuff);
        logic                    bits[$];
        logic [7:0]              sync_byte;
        usb_rx_pkg::line_state_e level;
        int                      run;
        logic                    skip_pending;
        sync_byte    = `USB_SYNC_BYTE;
        level        = usb_rx_pkg::J;
        run          = 0;
        skip_pending = skip_stuff;
        for (int i = 0; i < 8; i++) begin
            bits.push_back(sync_byte[i]);
        end
        foreach (tx_bytes[n]) begin
            for (int i = 0; i < 8; i++) begin
                bits.push_back(tx_bytes[n][i]);
            end
        end
        // Idle long enough for the decoder to leave any stuffing slot
        repeat (12) hold_symbol(usb_rx_pkg::J);
        foreach (bits[n]) begin
            if (!bits[n]) begin
                level = flip_symbol(level);
                run   = 0;
            end else begin
                run++;
            end
            hold_symbol(level);
            if (run == `USB_STUFF_RUN) begin
                run = 0;
                if (skip_pending) begin
                    skip_pending = 1'b0;
                end else begin
                    level = flip_symbol(level);
                    hold_symbol(level);
                end
            end
        end
        repeat (2) hold_symbol(usb_rx_pkg::SE0);
        hold_symbol(usb_rx_pkg::J);
    endtask

    task automatic wait_rx_active(input logic level, input int limit);
        int count;
        count = 0;
        while (rx_active !== level) begin
            if (count == limit) begin
                abort_run($sformatf("Timeout: rx_active did not go to %0b within %0d cycles",
                                    level, limit));
            end
            next_cycle();
            count++;
        end
    endtask

    task automatic wait_reset_detected(input logic level, input int limit, output int waited);
        waited = 0;
        while (reset_detected !== level) begin
            if (waited == limit) begin
                abort_run($sformatf("Timeout: reset_detected did not go to %0b within %0d cycles",
                                    level, limit));
            end
            next_cycle();
            waited++;
        end
    endtask

    task automatic clear_monitor();
        got_bytes.delete();
        active_seen = 1'b0;
        error_seen  = 1'b0;
    endtask

    // Sends tx_bytes and expects all of them back with no error
    task automatic receive_clean_packet();
        clear_monitor();
        send_packet(1'b0);
        wait_rx_active(1'b0, 40);
        repeat (4) next_cycle();
        check_flag("rx_active seen", 1'b1, active_seen);
        check_flag("rx_error seen", 1'b0, error_seen);
        if (got_bytes.size() != tx_bytes.size()) begin
            abort_run($sformatf("Received %0d bytes but %0d were sent",
                                got_bytes.size(), tx_bytes.size()));
        end
        foreach (tx_bytes[n]) begin
            check_byte($sformatf("rx_data[%0d]", n), tx_bytes[n], got_bytes[n]);
        end
    endtask

    task automatic hold_and_check(input usb_rx_pkg::line_state_e s);
        {dp, dm} = s;
        repeat (10) next_cycle();
        check_line("line_state", s, line_state);
        check_flag("j_state", s == usb_rx_pkg::J, j_state);
        check_flag("k_state", s == usb_rx_pkg::K, k_state);
        check_flag("se0_state", s == usb_rx_pkg::SE0, se0_state);
        check_flag("se1_state", s == usb_rx_pkg::SE1, se1_state);
        check_flag("reset_detected", 1'b0, reset_detected);
    endtask

    task automatic test_static_states();
        hold_and_check(usb_rx_pkg::J);
        hold_and_check(usb_rx_pkg::K);
        hold_and_check(usb_rx_pkg::SE0);
        hold_and_check(usb_rx_pkg::SE1);
        hold_and_check(usb_rx_pkg::J);
    endtask

    task automatic test_packet_reception();
        logic [7:0] b;
        tx_bytes.delete();
        repeat (10) begin
            take_random_byte(b);
            tx_bytes.push_back(b);
        end
        receive_clean_packet();
    endtask

    task automatic test_bit_stuffing();
        tx_bytes.delete();
        tx_bytes.push_back(8'hFF);
        tx_bytes.push_back(8'hFF);
        tx_bytes.push_back(8'h7E);
        receive_clean_packet();
    endtask

    // Run of ones crosses from the first into the second byte, so only 8'hA5 survives
    task automatic test_stuff_error();
        tx_bytes.delete();
        tx_bytes.push_back(8'hA5);
        tx_bytes.push_back(8'hFF);
        tx_bytes.push_back(8'h12);
        clear_monitor();
        send_packet(1'b1);
        wait_rx_active(1'b0, 40);
        repeat (4) next_cycle();
        check_flag("rx_error seen", 1'b1, error_seen);
        if (got_bytes.size() != 1) begin
            abort_run($sformatf("Received %0d bytes around a stuffing error, expected 1",
                                got_bytes.size()));
        end
        check_byte("rx_data[0]", 8'hA5, got_bytes[0]);
        check_flag("rx_active", 1'b0, rx_active);
    endtask

    task automatic test_bus_reset();
        int waited;
        // EOP-length SE0 must not look like a bus reset
        {dp, dm} = usb_rx_pkg::SE0;
        repeat (8) next_cycle();
        {dp, dm} = usb_rx_pkg::J;
        repeat (20) begin
            next_cycle();
            check_flag("reset_detected", 1'b0, reset_detected);
        end
        {dp, dm} = usb_rx_pkg::SE0;
        wait_reset_detected(1'b1, `USB_RESET_SE0_CYCLES + 10, waited);
        repeat (200 - waited) next_cycle();
        {dp, dm} = usb_rx_pkg::J;
        wait_reset_detected(1'b0, 10, waited);
    endtask

    initial begin
        rst_n       = 1'b0;
        dp          = 1'b1;
        dm          = 1'b0;
        lfsr        = 32'h2fff;
        active_seen = 1'b0;
        error_seen  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (10) next_cycle();
        test_static_states();
        test_packet_reception();
        test_bit_stuffing();
        test_stuff_error();
        test_bus_reset();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- usb_fs_rx.f
+incdir+include
hdl/usb_rx_pkg.sv
hdl/usb_line_state_detector.sv
hdl/usb_bit_sampler.sv
hdl/usb_nrzi_decoder.sv
hdl/usb_rx_packet.sv
hdl/usb_fs_rx.sv
tests/usb_fs_rx_assert.sv
tests/usb_fs_rx_tb.sv
